/* rtl/isa_pkg.sv */
package isa_pkg;

  localparam int NUM_REGS = 128;

  // register file words and addresses
  typedef logic [6:0]   reg_addr_t;
  typedef logic [127:0] reg_data_t;

  // only the opcodes the issue stage itself needs are named
  typedef enum logic [6:0] {
    op_none = 7'd0,
    op_lnop = 7'd85,
    op_nop  = 7'd86
  } op_t;

  typedef logic [2:0]  unit_t;
  typedef logic [3:0]  latency_t;
  typedef logic [17:0] imm18_t;
  typedef logic [9:0]  pc_t;

  // decoded instruction as handed to the fetch stage
  typedef struct packed {
    op_t       op;
    reg_addr_t reg_dst;
    unit_t     unit;
    latency_t  latency;
    logic      reg_wr;
    imm18_t    imm18;
  } instr_t;

  // source operands, index 0 is ra, 1 is rb, 2 is rc
  typedef reg_data_t [0:2] operands_t;

  // bubbles inserted on flush
  localparam instr_t INSTR_NOP = '{
    op: op_nop, reg_dst: '0, unit: '0, latency: '0, reg_wr: 1'b0, imm18: '0
  };
  localparam instr_t INSTR_LNOP = '{
    op: op_lnop, reg_dst: '0, unit: '0, latency: '0, reg_wr: 1'b0, imm18: '0
  };

endpackage

/* rtl/fwd_pkg.sv */
package fwd_pkg;

  import isa_pkg::*;

  // pipeline stages whose results can still be forwarded
  localparam int FIRST_FWD_STAGE = 2;
  localparam int LAST_FWD_STAGE  = 7;
  localparam int NUM_FWD_STAGES  = LAST_FWD_STAGE - FIRST_FWD_STAGE + 1;

  // what forwarding needs from one in-flight stage
  typedef struct packed {
    logic      wr;
    reg_addr_t dst;
    reg_data_t data;
  } stage_result_t;

  // one entry per stage, index 0 is the youngest (stage 2)
  typedef stage_result_t [NUM_FWD_STAGES-1:0] stage_results_t;

endpackage

/* rtl/rf_read_if.sv */
interface rf_read_if
  import isa_pkg::*;
();

  // ra, rb, rc of one pipe
  reg_addr_t [0:2] addr;
  operands_t       data;

  // register file answers the addresses
  modport rf (
    input  addr,
    output data
  );

  // operand selector looks at both
  modport sel (
    input addr,
    input data
  );

endinterface

/* rtl/reg_file.sv */
module reg_file
  import isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_en_1,
  input  logic      wr_en_2,
  input  reg_addr_t wr_addr_1,
  input  reg_addr_t wr_addr_2,
  input  reg_data_t wr_data_1,
  input  reg_data_t wr_data_2,
  rf_read_if.rf     rd_even,
  rf_read_if.rf     rd_odd
);

  reg_data_t regs [NUM_REGS];

  // two write ports, port 2 issued last so it wins a collision
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_en_1) begin
        regs[wr_addr_1] <= wr_data_1;
      end
      if (wr_en_2) begin
        regs[wr_addr_2] <= wr_data_2;
      end
    end
  end

  // six asynchronous reads, old data during a same-cycle write
  for (genvar s = 0; s < 3; s++) begin : g_read
    assign rd_even.data[s] = regs[rd_even.addr[s]];
    assign rd_odd.data[s]  = regs[rd_odd.addr[s]];
  end

endmodule

/* rtl/fwd_select.sv */
module fwd_select
  import isa_pkg::*;
  import fwd_pkg::*;
(
  rf_read_if.sel         rd,
  input  stage_results_t own,
  input  stage_results_t other,
  output operands_t      operands
);

  // first hit wins, scanning youngest stage first
  // and within a stage the consuming pipe before the other one
  function automatic reg_data_t resolve(
    input reg_addr_t      src,
    input reg_data_t      rf_data,
    input stage_results_t own_r,
    input stage_results_t other_r
  );
    reg_data_t result;
    logic      found;
    result = rf_data;
    found  = 1'b0;
    for (int k = 0; k < NUM_FWD_STAGES; k++) begin
      if (!found && own_r[k].wr && (own_r[k].dst == src)) begin
        result = own_r[k].data;
        found  = 1'b1;
      end
      if (!found && other_r[k].wr && (other_r[k].dst == src)) begin
        result = other_r[k].data;
        found  = 1'b1;
      end
    end
    return result;
  endfunction

  // one resolver per source: ra, rb, rc
  for (genvar s = 0; s < 3; s++) begin : g_src
    assign operands[s] = resolve(rd.addr[s], rd.data[s], own, other);
  end

endmodule

/* rtl/issue_latch.sv */
module issue_latch
  import isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  instr_t    instr_even,
  input  instr_t    instr_odd,
  input  operands_t opnd_even,
  input  operands_t opnd_odd,
  input  pc_t       pc,
  input  logic      branch,
  output instr_t    out_instr_even,
  output instr_t    out_instr_odd,
  output operands_t out_opnd_even,
  output operands_t out_opnd_odd,
  output pc_t       pc_out,
  output logic      branch_out
);

  // instruction and operand register, flush turns both pipes into bubbles
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_instr_even <= '0;
      out_instr_odd  <= '0;
      out_opnd_even  <= '0;
      out_opnd_odd   <= '0;
    end else if (flush) begin
      out_instr_even <= INSTR_NOP;
      out_instr_odd  <= INSTR_LNOP;
      out_opnd_even  <= '0;
      out_opnd_odd   <= '0;
    end else begin
      out_instr_even <= instr_even;
      out_instr_odd  <= instr_odd;
      out_opnd_even  <= opnd_even;
      out_opnd_odd   <= opnd_odd;
    end
  end

  // pc and branch flag keep moving through a flush
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_out     <= '0;
      branch_out <= 1'b0;
    end else begin
      pc_out     <= pc;
      branch_out <= branch;
    end
  end

endmodule

/* rtl/operand_fetch.sv */
module operand_fetch
  import isa_pkg::*;
  import fwd_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  pc_t             pc,
  input  logic            branch,

  // decoded instructions of both pipes
  input  instr_t          instr_even,
  input  instr_t          instr_odd,

  // source registers, ra rb rc
  input  reg_addr_t [0:2] src_even,
  input  reg_addr_t [0:2] src_odd,

  // writeback into the register file
  input  logic            wr_en_1,
  input  logic            wr_en_2,
  input  reg_addr_t       wr_addr_1,
  input  reg_addr_t       wr_addr_2,
  input  reg_data_t       wr_data_1,
  input  reg_data_t       wr_data_2,

  // results in flight, stages 2 to 7 of each pipe
  input  stage_results_t  results_even,
  input  stage_results_t  results_odd,

  output instr_t          out_instr_even,
  output instr_t          out_instr_odd,
  output operands_t       out_opnd_even,
  output operands_t       out_opnd_odd,
  output pc_t             pc_out,
  output logic            branch_out
);

  operands_t opnd_even;
  operands_t opnd_odd;

  rf_read_if rd_even ();
  rf_read_if rd_odd ();

  assign rd_even.addr = src_even;
  assign rd_odd.addr  = src_odd;

  reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .wr_en_1   (wr_en_1),
    .wr_en_2   (wr_en_2),
    .wr_addr_1 (wr_addr_1),
    .wr_addr_2 (wr_addr_2),
    .wr_data_1 (wr_data_1),
    .wr_data_2 (wr_data_2),
    .rd_even   (rd_even),
    .rd_odd    (rd_odd)
  );

  // each selector sees its own pipe first
  fwd_select sel_even (
    .rd       (rd_even),
    .own      (results_even),
    .other    (results_odd),
    .operands (opnd_even)
  );

  fwd_select sel_odd (
    .rd       (rd_odd),
    .own      (results_odd),
    .other    (results_even),
    .operands (opnd_odd)
  );

  issue_latch u_issue_latch (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .instr_even     (instr_even),
    .instr_odd      (instr_odd),
    .opnd_even      (opnd_even),
    .opnd_odd       (opnd_odd),
    .pc             (pc),
    .branch         (branch),
    .out_instr_even (out_instr_even),
    .out_instr_odd  (out_instr_odd),
    .out_opnd_even  (out_opnd_even),
    .out_opnd_odd   (out_opnd_odd),
    .pc_out         (pc_out),
    .branch_out     (branch_out)
  );

endmodule

/* test/operand_fetch_assertions.sv */
module operand_fetch_assertions
  import isa_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   flush,
  input pc_t    pc,
  input instr_t out_instr_even,
  input instr_t out_instr_odd,
  input pc_t    pc_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // a flushed slot never writes back
  flush_clears_reg_wr: assert property (
    @(posedge clk) disable iff (rst)
    flush |=> (!out_instr_even.reg_wr && !out_instr_odd.reg_wr)
  ) else $error("reg_wr still set in the cycle after a flush");

  flush_inserts_bubbles: assert property (
    @(posedge clk) disable iff (rst)
    flush |=> (out_instr_even.op == op_nop && out_instr_odd.op == op_lnop)
  ) else $error("ops are not nop and lnop after a flush");

  // pc moves through regardless of flush
  pc_follows_input: assert property (
    @(posedge clk) disable iff (rst)
    !rst |=> (pc_out == $past(pc))
  ) else $error("pc_out differs from the pc of the previous cycle");

endmodule

bind operand_fetch operand_fetch_assertions u_assertions (
  .clk            (clk),
  .rst            (rst),
  .flush          (flush),
  .pc             (pc),
  .out_instr_even (out_instr_even),
  .out_instr_odd  (out_instr_odd),
  .pc_out         (pc_out)
);

/* test/operand_fetch_tb.sv */
module operand_fetch_tb
  import isa_pkg::*;
  import fwd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic            clk = 1'b0;
  logic            rst;
  logic            flush;
  pc_t             pc;
  logic            branch;
  instr_t          instr_even;
  instr_t          instr_odd;
  reg_addr_t [0:2] src_even;
  reg_addr_t [0:2] src_odd;
  logic            wr_en_1;
  logic            wr_en_2;
  reg_addr_t       wr_addr_1;
  reg_addr_t       wr_addr_2;
  reg_data_t       wr_data_1;
  reg_data_t       wr_data_2;
  stage_results_t  results_even;
  stage_results_t  results_odd;
  instr_t          out_instr_even;
  instr_t          out_instr_odd;
  operands_t       out_opnd_even;
  operands_t       out_opnd_odd;
  pc_t             pc_out;
  logic            branch_out;

  // reference state
  reg_data_t   shadow [NUM_REGS];
  instr_t      exp_instr_even;
  instr_t      exp_instr_odd;
  operands_t   exp_opnd_even;
  operands_t   exp_opnd_odd;
  pc_t         exp_pc;
  logic        exp_branch;
  logic        exp_valid = 1'b0;
  int unsigned edge_count = 0;
  reg_addr_t   last_addr_1;
  reg_addr_t   last_addr_2;

  operand_fetch dut (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .pc             (pc),
    .branch         (branch),
    .instr_even     (instr_even),
    .instr_odd      (instr_odd),
    .src_even       (src_even),
    .src_odd        (src_odd),
    .wr_en_1        (wr_en_1),
    .wr_en_2        (wr_en_2),
    .wr_addr_1      (wr_addr_1),
    .wr_addr_2      (wr_addr_2),
    .wr_data_1      (wr_data_1),
    .wr_data_2      (wr_data_2),
    .results_even   (results_even),
    .results_odd    (results_odd),
    .out_instr_even (out_instr_even),
    .out_instr_odd  (out_instr_odd),
    .out_opnd_even  (out_opnd_even),
    .out_opnd_odd   (out_opnd_odd),
    .pc_out         (pc_out),
    .branch_out     (branch_out)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edge_count = edge_count + 1;
  end

  // scan oldest stage first so a younger hit overwrites
  // and apply the own pipe last within a stage
  function automatic reg_data_t resolve_operand(
    input reg_addr_t      src,
    input stage_results_t own,
    input stage_results_t other,
    input reg_data_t      regs [NUM_REGS]
  );
    reg_data_t val;
    val = regs[src];
    for (int k = NUM_FWD_STAGES - 1; k >= 0; k--) begin
      if (other[k].wr && other[k].dst == src) begin
        val = other[k].data;
      end
      if (own[k].wr && own[k].dst == src) begin
        val = own[k].data;
      end
    end
    return val;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_operands(input string name, input operands_t exp,
                                input operands_t act);
    for (int s = 0; s < 3; s++) begin
      if (act[s] !== exp[s]) begin
        $display("Mismatch at %0t: %s[%0d] expected %h actual %h",
                 $time, name, s, exp[s], act[s]);
        abort_run();
      end
    end
  endtask

  task automatic check_pc(input pc_t exp_p, input logic exp_b, input pc_t act_p,
                          input logic act_b);
    if (act_p !== exp_p) begin
      $display("Mismatch at %0t: pc_out expected %h actual %h", $time, exp_p, act_p);
      abort_run();
    end
    if (act_b !== exp_b) begin
      $display("Mismatch at %0t: branch_out expected %b actual %b", $time, exp_b, act_b);
      abort_run();
    end
  endtask

  // wait for the next rising edge and step 1 ns past it
  task automatic next_cycle();
    int unsigned start;
    int          polls;
    start = edge_count;
    polls = 0;
    // polls sit on half ns points away from the edges
    #0.5;
    while (edge_count == start && polls < 20) begin
      #1;
      polls++;
    end
    if (edge_count == start) begin
      $display("Timeout: no rising clock edge seen within %0d ns", polls + 1);
      abort_run();
    end else begin
      #0.5;
    end
  endtask

  function automatic reg_data_t random_data();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // pool of 0 means any register
  function automatic reg_addr_t pick_addr(input int pool);
    if (pool == 0) begin
      return reg_addr_t'($urandom());
    end
    return reg_addr_t'($urandom_range(pool - 1, 0));
  endfunction

  function automatic instr_t random_instr();
    instr_t ins;
    ins.op      = op_t'(7'($urandom()));
    ins.reg_dst = reg_addr_t'($urandom());
    ins.unit    = unit_t'($urandom());
    ins.latency = latency_t'($urandom());
    ins.reg_wr  = 1'($urandom());
    ins.imm18   = imm18_t'($urandom());
    return ins;
  endfunction

  function automatic stage_results_t random_results(input int pool);
    stage_results_t r;
    for (int k = 0; k < NUM_FWD_STAGES; k++) begin
      r[k].wr   = 1'($urandom());
      r[k].dst  = pick_addr(pool);
      r[k].data = random_data();
    end
    return r;
  endfunction

  task automatic clear_inputs();
    flush        = 1'b0;
    pc           = '0;
    branch       = 1'b0;
    instr_even   = '0;
    instr_odd    = '0;
    src_even     = '0;
    src_odd      = '0;
    wr_en_1      = 1'b0;
    wr_en_2      = 1'b0;
    wr_addr_1    = '0;
    wr_addr_2    = '0;
    wr_data_1    = '0;
    wr_data_2    = '0;
    results_even = '0;
    results_odd  = '0;
  endtask

  task automatic drive_random(input int pool, input bit use_results, input bit do_flush);
    instr_even = random_instr();
    instr_odd  = random_instr();
    for (int s = 0; s < 3; s++) begin
      src_even[s] = pick_addr(pool);
      src_odd[s]  = pick_addr(pool);
    end
    wr_en_1      = 1'($urandom());
    wr_en_2      = 1'($urandom());
    wr_addr_1    = pick_addr(pool);
    wr_addr_2    = pick_addr(pool);
    wr_data_1    = random_data();
    wr_data_2    = random_data();
    results_even = use_results ? random_results(pool) : '0;
    results_odd  = use_results ? random_results(pool) : '0;
    pc           = pc_t'($urandom());
    branch       = 1'($urandom());
    flush        = do_flush;
  endtask

  // reference model samples inputs at the rising edge
  always @(posedge clk) begin
    if (rst) begin
      exp_instr_even = '0;
      exp_instr_odd  = '0;
      exp_opnd_even  = '0;
      exp_opnd_odd   = '0;
      exp_pc         = '0;
      exp_branch     = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        shadow[i] = '0;
      end
    end else begin
      if (flush) begin
        exp_instr_even    = '0;
        exp_instr_even.op = op_nop;
        exp_instr_odd     = '0;
        exp_instr_odd.op  = op_lnop;
        exp_opnd_even     = '0;
        exp_opnd_odd      = '0;
      end else begin
        exp_instr_even = instr_even;
        exp_instr_odd  = instr_odd;
        for (int s = 0; s < 3; s++) begin
          exp_opnd_even[s] = resolve_operand(src_even[s], results_even, results_odd, shadow);
          exp_opnd_odd[s]  = resolve_operand(src_odd[s], results_odd, results_even, shadow);
        end
      end
      exp_pc     = pc;
      exp_branch = branch;
      // writes land after this edge's reads and port 2 goes last
      if (wr_en_1) begin
        shadow[wr_addr_1] = wr_data_1;
      end
      if (wr_en_2) begin
        shadow[wr_addr_2] = wr_data_2;
      end
    end
    exp_valid = 1'b1;
  end

  // outputs have settled by the falling edge
  always @(negedge clk) begin
    if (exp_valid) begin
      check_instr("out_instr_even", exp_instr_even, out_instr_even);
      check_instr("out_instr_odd", exp_instr_odd, out_instr_odd);
      check_operands("out_opnd_even", exp_opnd_even, out_opnd_even);
      check_operands("out_opnd_odd", exp_opnd_odd, out_opnd_odd);
      check_pc(exp_pc, exp_branch, pc_out, branch_out);
    end
  end

  initial begin
    void'($urandom(51));
    clear_inputs();
    rst = 1'b1;
    // live instructions at the inputs must not get past reset
    for (int i = 0; i < 10; i++) begin
      instr_even = random_instr();
      instr_odd  = random_instr();
      pc         = pc_t'($urandom());
      branch     = 1'($urandom());
      next_cycle();
    end
    rst = 1'b0;
    clear_inputs();
    next_cycle();

    // register file alone with read back one cycle after each write
    last_addr_1 = '0;
    last_addr_2 = '0;
    for (int i = 0; i < 48; i++) begin
      drive_random(0, 1'b0, 1'b0);
      wr_en_1 = 1'b1;
      wr_en_2 = 1'b1;
      // both ports on one register now and then
      if (i % 8 == 7) begin
        wr_addr_2 = wr_addr_1;
      end
      src_even[0] = last_addr_1;
      src_even[1] = last_addr_2;
      src_even[2] = last_addr_2;
      src_odd[0]  = last_addr_2;
      src_odd[1]  = last_addr_1;
      src_odd[2]  = last_addr_1;
      last_addr_1 = wr_addr_1;
      last_addr_2 = wr_addr_2;
      next_cycle();
    end

    // small address pool so stages and pipes collide often
    for (int i = 0; i < 300; i++) begin
      drive_random(4, 1'b1, 1'b0);
      next_cycle();
    end

    // read and write one register in the same cycle
    for (int i = 0; i < 40; i++) begin
      drive_random(4, 1'b0, 1'b0);
      wr_en_1     = 1'b1;
      wr_en_2     = 1'b0;
      src_even[0] = wr_addr_1;
      src_odd[1]  = wr_addr_1;
      if (i % 2 == 1) begin
        results_odd[3].wr   = 1'b1;
        results_odd[3].dst  = wr_addr_1;
        results_odd[3].data = random_data();
      end
      next_cycle();
    end

    for (int i = 0; i < 12; i++) begin
      drive_random(8, 1'b1, (i % 3) == 0);
      next_cycle();
    end

    for (int i = 0; i < 2000; i++) begin
      drive_random((i % 4 == 0) ? 0 : 16, 1'b1, $urandom_range(15, 0) == 0);
      next_cycle();
    end

    clear_inputs();
    next_cycle();
    next_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* sources.f */
rtl/isa_pkg.sv
rtl/fwd_pkg.sv
rtl/rf_read_if.sv
rtl/reg_file.sv
rtl/fwd_select.sv
rtl/issue_latch.sv
rtl/operand_fetch.sv
test/operand_fetch_assertions.sv
test/operand_fetch_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module operand_fetch_tb -f sources.f -o sim > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
grep -q 'All tests passed!' sim.log && echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }
